//--- rtl/acum_pkg.sv
////////////////////
// two-channel averager shared definitions
// default widths, sample and sum types, trigger states
////////////////////

package acum_pkg;

  // default widths, the top passes them down per instance
  parameter int IDW = 14;         // adc sample width
  parameter int ACW = 8;          // pass counter width
  parameter int AAW = 4;          // memory address width, 16 words
  parameter int ODW = IDW + ACW;  // result width, no overflow over 2**ACW passes

  typedef logic signed [IDW-1:0] smp_t;  // signed adc sample
  typedef logic signed [ODW-1:0] sum_t;  // one accumulated result
  typedef logic        [AAW-1:0] adr_t;  // memory index
  typedef logic        [ACW-1:0] cnt_t;  // pass count

  // level trigger states
  typedef enum logic [1:0] {
    idle,   // waiting for a sample below level
    armed,  // below level seen
    fired   // crossing found, pass running
  } trig_st_t;

endpackage

//--- rtl/acum_trig.sv
////////////////////
// level trigger on channel a
// one-cycle pulse on an upward crossing of cfg_lvl
////////////////////

module acum_trig
  import acum_pkg::*;
(
  input  logic     clk,
  input  logic     rst,      // sync, active high
  input  logic     clr,      // sync clear
  input  logic     run,      // accumulator running
  input  logic     xfer,     // input beat transferred
  input  smp_t     smp,      // channel a sample
  input  smp_t     cfg_lvl,  // trigger level
  input  logic     busy,     // pass under way in the cores
  output logic     trg       // crossing pulse
);

trig_st_t st;     // trigger state
logic     below;  // current sample under level

// signed compare, both sides smp_t
assign below = smp < cfg_lvl;

////////////////////
// state machine
////////////////////

always_ff @(posedge clk) begin
  if (rst || clr) begin
    st <= idle;
  end else begin
    case (st)
      // need a fresh sample under the level first
      idle: if (run && !busy && xfer && below) st <= armed;
      armed: begin
        if (!run)                st <= idle;
        else if (xfer && !below) st <= fired;  // upward crossing
      end
      // hold off until the pass is done
      fired: if (!busy) st <= idle;
      default: st <= idle;
    endcase
  end
end

// pulse on the crossing beat itself, the cores take this beat as index 0
assign trg = (st == armed) & run & xfer & !below;

endmodule

//--- rtl/acum_core.sv
////////////////////
// per-channel accumulator core
// adds cfg_len+1 samples per pass into a result memory,
// streams the final pass out and serves bus reads when idle
////////////////////

module acum_core
  import acum_pkg::*;
#(
  parameter int IDW = acum_pkg::IDW,  // sample width
  parameter int ACW = acum_pkg::ACW,  // pass counter width
  parameter int AAW = acum_pkg::AAW   // memory address width
)(
  input  logic clk,
  input  logic rst,        // sync, active high
  input  logic clr,        // sync clear
  input  logic ctl_run,    // start pulse
  // configuration
  input  cnt_t cfg_cnt,    // passes minus one
  input  adr_t cfg_len,    // samples per pass minus one
  // input stream
  input  logic trg,        // pass start from the trigger
  input  logic in_valid,
  input  logic in_ready,
  input  smp_t smp,
  // status
  output logic busy,       // pass under way
  output logic run,        // run active
  output cnt_t cnt,        // current pass
  // final pass results
  output logic res_valid,
  output logic res_last,
  output sum_t res_data,
  // read bus
  input  logic bus_ren,
  input  adr_t bus_adr,
  output sum_t bus_rdt
);

////////////////////
// local signals
////////////////////

logic acc_vld;  // beat eligible for accumulation
logic xfr;      // beat accepted
adr_t smp_cnt;  // index within the pass
logic smp_lst;  // last index of the pass
logic pas_end;  // in the final pass
logic run_end;  // final beat of the final pass

// pipeline stage 1, memory read in flight
logic s1_vld;
adr_t s1_adr;
smp_t s1_smp;
logic s1_beg;   // pass 0, start from zero
logic s1_fin;   // final pass
logic s1_lst;

// pipeline stage 2, sum registered
logic s2_vld;
adr_t s2_adr;
sum_t s2_sum;
logic s2_fin;
logic s2_lst;

// result memory
sum_t mem [2**AAW];
logic mem_ren;
adr_t mem_rad;
sum_t mem_rdt;
sum_t ext;      // sign-extended sample

////////////////////
// input side
////////////////////

assign busy    = smp_cnt != '0;
// first sample needs a trigger, the rest follow the pass
assign acc_vld = in_valid & run & (trg | busy);
assign xfr     = acc_vld & in_ready;
assign smp_lst = smp_cnt == cfg_len;
assign pas_end = cnt == cfg_cnt;
assign run_end = xfr & smp_lst & pas_end;

// sample index
always_ff @(posedge clk) begin
  if (rst || clr)  smp_cnt <= '0;
  else if (xfr)    smp_cnt <= smp_lst ? '0 : smp_cnt + 1'b1;
end

// pass counter, wraps after the final pass
always_ff @(posedge clk) begin
  if (rst || clr)             cnt <= '0;
  else if (xfr && smp_lst)    cnt <= pas_end ? '0 : cnt + 1'b1;
end

// run flag
always_ff @(posedge clk) begin
  if (rst || clr)    run <= 1'b0;
  else if (ctl_run)  run <= 1'b1;
  else if (run_end)  run <= 1'b0;
end

////////////////////
// accumulate pipeline
////////////////////

// valids
always_ff @(posedge clk) begin
  if (rst || clr) begin
    s1_vld <= 1'b0;
    s2_vld <= 1'b0;
  end else begin
    s1_vld <= xfr;
    s2_vld <= s1_vld;
  end
end

// stage 1 payload, lines up with mem_rdt
always_ff @(posedge clk) begin
  if (xfr) begin
    s1_adr <= smp_cnt;
    s1_smp <= smp;
    s1_beg <= cnt == '0;
    s1_fin <= pas_end;
    s1_lst <= smp_lst;
  end
end

assign ext = {{ACW{s1_smp[IDW-1]}}, s1_smp};

// stage 2, old sum plus sample
always_ff @(posedge clk) begin
  if (s1_vld) begin
    s2_adr <= s1_adr;
    s2_sum <= (s1_beg ? '0 : mem_rdt) + ext;
    s2_fin <= s1_fin;
    s2_lst <= s1_lst;
  end
end

// write back, third cycle after accept
always_ff @(posedge clk) begin
  if (s2_vld) mem[s2_adr] <= s2_sum;
end

// read port shared with the bus when not running
assign mem_ren = run ? xfr     : bus_ren;
assign mem_rad = run ? smp_cnt : bus_adr;

always_ff @(posedge clk) begin
  if (mem_ren) mem_rdt <= mem[mem_rad];
end

assign bus_rdt = mem_rdt;

////////////////////
// final pass output
////////////////////

always_ff @(posedge clk) begin
  if (rst || clr)  res_valid <= 1'b0;
  else             res_valid <= s2_vld & s2_fin;
end

always_ff @(posedge clk) begin
  if (s2_vld && s2_fin) begin
    res_data <= s2_sum;  // same value as the write
    res_last <= s2_lst;
  end
end

endmodule

//--- rtl/acum_combine.sv
////////////////////
// result combiner
// pairs the lockstep core outputs in a credit-counted FIFO,
// muxes bus read data by channel
////////////////////

module acum_combine
  import acum_pkg::*;
#(
  parameter int IDW = acum_pkg::IDW,  // sample width
  parameter int ACW = acum_pkg::ACW   // pass counter width
)(
  input  logic clk,
  input  logic rst,        // sync, active high
  input  logic clr,        // sync clear
  // core results, b runs in lockstep with a
  input  logic a_valid,
  input  logic a_last,
  input  sum_t a_data,
  input  sum_t b_data,
  output logic in_ready,   // input stream ready
  // output stream
  output logic sto_valid,
  output logic sto_last,
  output sum_t sto_a,
  output sum_t sto_b,
  input  logic sto_ready,
  // read bus
  input  logic bus_ren,
  input  logic bus_ch,     // 0 channel a, 1 channel b
  input  sum_t a_rdt,
  input  sum_t b_rdt,
  output sum_t bus_rdt,
  output logic bus_vld
);

localparam int DEP = 4;             // fifo entries
localparam int PW  = $clog2(DEP);   // pointer width
localparam int LAT = 3;             // core accept to result
localparam logic [PW:0] FULL = (PW+1)'(DEP);

logic [IDW+ACW-1:0] fifo_a [DEP];
logic [IDW+ACW-1:0] fifo_b [DEP];
logic [DEP-1:0]     fifo_l;         // last flags
logic [PW-1:0]      wr_ptr;
logic [PW-1:0]      rd_ptr;
logic [PW:0]        fill;           // entries held
logic [PW:0]        free;           // free slots, one leaving now counts
logic [LAT-1:0]     hst;            // in_ready over the last cycles
logic [PW:0]        flight;         // results possibly in the core pipeline
logic               push;
logic               pop;
logic               ch_q;           // channel of the pending bus read

////////////////////
// credit check
////////////////////

assign push = a_valid;
assign pop  = sto_valid & sto_ready;

// every ready cycle may have taken a final-pass beat
always_ff @(posedge clk) begin
  if (rst || clr)  hst <= '0;
  else             hst <= {hst[LAT-2:0], in_ready};
end

assign flight   = (PW+1)'(hst[0]) + (PW+1)'(hst[1]) + (PW+1)'(hst[2]);
assign free     = FULL - fill + (PW+1)'(pop);
assign in_ready = free > flight;  // room for one more, never drops

////////////////////
// fifo
////////////////////

always_ff @(posedge clk) begin
  if (rst || clr) begin
    wr_ptr <= '0;
    rd_ptr <= '0;
    fill   <= '0;
  end else begin
    if (push) wr_ptr <= wr_ptr + 1'b1;
    if (pop)  rd_ptr <= rd_ptr + 1'b1;
    fill <= fill + (PW+1)'(push) - (PW+1)'(pop);
  end
end

always_ff @(posedge clk) begin
  if (push) begin
    fifo_a[wr_ptr] <= a_data;
    fifo_b[wr_ptr] <= b_data;
    fifo_l[wr_ptr] <= a_last;
  end
end

assign sto_valid = fill != '0;  // entry shows up one cycle after push
assign sto_a     = fifo_a[rd_ptr];
assign sto_b     = fifo_b[rd_ptr];
assign sto_last  = fifo_l[rd_ptr];

////////////////////
// read bus
////////////////////

always_ff @(posedge clk) begin
  if (bus_ren) ch_q <= bus_ch;
end

always_ff @(posedge clk) begin
  if (rst || clr)  bus_vld <= 1'b0;
  else             bus_vld <= bus_ren;  // core memories read in one cycle
end

assign bus_rdt = ch_q ? b_rdt : a_rdt;

endmodule

//--- rtl/acum_top.sv
////////////////////
// two-channel signal averager
// trigger, two lockstep accumulator cores, result combiner
////////////////////

module acum_top
  import acum_pkg::*;
#(
  parameter int IDW = acum_pkg::IDW,  // sample width
  parameter int ACW = acum_pkg::ACW,  // pass counter width
  parameter int AAW = acum_pkg::AAW   // memory address width
)(
  input  logic clk,
  input  logic rst,        // sync, active high
  input  logic clr,        // sync clear
  input  logic ctl_run,    // start pulse
  // configuration
  input  cnt_t cfg_cnt,    // passes minus one
  input  adr_t cfg_len,    // samples per pass minus one
  input  smp_t cfg_lvl,    // trigger level on channel a
  // status
  output logic sts_run,
  output cnt_t sts_cnt,
  // input stream, one sample per channel
  input  logic sti_valid,
  input  smp_t sti_a,
  input  smp_t sti_b,
  output logic sti_ready,
  // output stream, sums side by side
  output logic sto_valid,
  output logic sto_last,
  output sum_t sto_a,
  output sum_t sto_b,
  input  logic sto_ready,
  // read bus, only while not running
  input  logic bus_ren,
  input  logic bus_ch,
  input  adr_t bus_adr,
  output sum_t bus_rdt,
  output logic bus_vld
);

logic trg;      // pass start
logic a_busy;   // pass under way, core a
logic sti_xfr;  // input beat transferred
logic a_valid;
logic a_last;
sum_t a_data;
sum_t b_data;
sum_t a_rdt;
sum_t b_rdt;

assign sti_xfr = sti_valid & sti_ready;

////////////////////
// trigger
////////////////////

acum_trig u_trig (
  .clk     (clk),
  .rst     (rst),
  .clr     (clr),
  .run     (sts_run),
  .xfer    (sti_xfr),
  .smp     (sti_a),
  .cfg_lvl (cfg_lvl),
  .busy    (a_busy),
  .trg     (trg)
);

////////////////////
// cores
////////////////////

// core a also owns the status
acum_core #(.IDW(IDW), .ACW(ACW), .AAW(AAW)) u_core_a (
  .clk       (clk),
  .rst       (rst),
  .clr       (clr),
  .ctl_run   (ctl_run),
  .cfg_cnt   (cfg_cnt),
  .cfg_len   (cfg_len),
  .trg       (trg),
  .in_valid  (sti_valid),
  .in_ready  (sti_ready),
  .smp       (sti_a),
  .busy      (a_busy),
  .run       (sts_run),
  .cnt       (sts_cnt),
  .res_valid (a_valid),
  .res_last  (a_last),
  .res_data  (a_data),
  .bus_ren   (bus_ren),
  .bus_adr   (bus_adr),
  .bus_rdt   (a_rdt)
);

// lockstep with a, only data is used
acum_core #(.IDW(IDW), .ACW(ACW), .AAW(AAW)) u_core_b (
  .clk       (clk),
  .rst       (rst),
  .clr       (clr),
  .ctl_run   (ctl_run),
  .cfg_cnt   (cfg_cnt),
  .cfg_len   (cfg_len),
  .trg       (trg),
  .in_valid  (sti_valid),
  .in_ready  (sti_ready),
  .smp       (sti_b),
  .busy      (),
  .run       (),
  .cnt       (),
  .res_valid (),
  .res_last  (),
  .res_data  (b_data),
  .bus_ren   (bus_ren),
  .bus_adr   (bus_adr),
  .bus_rdt   (b_rdt)
);

////////////////////
// combiner
////////////////////

acum_combine #(.IDW(IDW), .ACW(ACW)) u_combine (
  .clk       (clk),
  .rst       (rst),
  .clr       (clr),
  .a_valid   (a_valid),
  .a_last    (a_last),
  .a_data    (a_data),
  .b_data    (b_data),
  .in_ready  (sti_ready),
  .sto_valid (sto_valid),
  .sto_last  (sto_last),
  .sto_a     (sto_a),
  .sto_b     (sto_b),
  .sto_ready (sto_ready),
  .bus_ren   (bus_ren),
  .bus_ch    (bus_ch),
  .a_rdt     (a_rdt),
  .b_rdt     (b_rdt),
  .bus_rdt   (bus_rdt),
  .bus_vld   (bus_vld)
);

endmodule

//--- dv/acum_tb.sv
////////////////////
// averager testbench
// file-driven runs with random output back-pressure,
// final-pass stream and bus readback against file sums
////////////////////

module acum_tb
  import acum_pkg::*;
();

localparam int NRUN  = 4;   // run records at most
localparam int NSMP  = 64;  // sample pairs per run at most
localparam int NBEAT = 64;  // output beats kept

// dut inputs, all start defined
logic clk       = 1'b0;
logic rst       = 1'b1;
logic clr       = 1'b0;
logic ctl_run   = 1'b0;
cnt_t cfg_cnt   = '0;
adr_t cfg_len   = '0;
smp_t cfg_lvl   = '0;
logic sti_valid = 1'b0;
smp_t sti_a     = '0;
smp_t sti_b     = '0;
logic sto_ready = 1'b0;
logic bus_ren   = 1'b0;
logic bus_ch    = 1'b0;
adr_t bus_adr   = '0;

// dut outputs
logic sts_run;
cnt_t sts_cnt;
logic sti_ready;
logic sto_valid;
logic sto_last;
sum_t sto_a;
sum_t sto_b;
sum_t bus_rdt;
logic bus_vld;

// run records from the data file
int nrun;
int tot_smp;
int len  [NRUN];
int cnt  [NRUN];
int lvl  [NRUN];
int nsmp [NRUN];
int sa   [NRUN][NSMP];    // channel a samples
int sb   [NRUN][NSMP];    // channel b samples
int ea   [NRUN][2**AAW];  // expected sums per index
int eb   [NRUN][2**AAW];

// captured output beats
sum_t got_a [NBEAT];
sum_t got_b [NBEAT];
logic got_l [NBEAT];
int   beat_tot = 0;  // beats seen since start
int   run_base = 0;  // first beat of the current run

int          err_mis = 0;
int          err_oth = 0;
int          cyc     = 0;
int          limit   = 500;  // raised once the file is read
logic [31:0] seed    = 32'h50aa_6021;
logic        load_ok;

always #2 clk = ~clk;  // period 4

acum_top #(.IDW(IDW), .ACW(ACW), .AAW(AAW)) acum_top_i (.*);

////////////////////
// back-pressure, capture, watchdog
////////////////////

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

always @(posedge clk) begin
  seed = lcg_next(seed);
  sto_ready <= seed[21];  // about half the cycles
end

always @(posedge clk) begin
  if (!rst && sto_valid && sto_ready) begin
    if (beat_tot < NBEAT) begin
      got_a[beat_tot] <= sto_a;
      got_b[beat_tot] <= sto_b;
      got_l[beat_tot] <= sto_last;
    end
    beat_tot <= beat_tot + 1;
  end
end

always @(posedge clk) begin
  cyc <= cyc + 1;
  if (cyc >= limit) begin
    $display("timeout: the runs did not finish within %0d cycles", limit);
    $display("error counts: %0d mismatches, %0d other, 1 timeout", err_mis, err_oth);
    $display("SIMULATION FAILED");
    $finish;
  end
end

////////////////////
// compare tasks
////////////////////

task automatic check_sum(input string name, input sum_t exp, input sum_t act);
  if (act !== exp) begin
    err_mis++;
    $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
  end
endtask

task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
  if (act !== exp) begin
    err_mis++;
    $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    err_mis++;
    $display("MISMATCH %s: expected %0b, actual %0b", name, exp, act);
  end
endtask

////////////////////
// data file
////////////////////

task automatic load_data(output logic ok);
  int    fd;
  int    n;
  int    r;
  int    i;
  int    va;
  int    vb;
  int    vc;
  int    vd;
  string line;
  ok = 1'b0;
  fd = $fopen("dv/acum_testdata.txt", "r");
  if (fd == 0) return;
  void'($fgets(line, fd));  // two column description lines
  void'($fgets(line, fd));
  n       = $fscanf(fd, "%d", nrun);
  ok      = (n == 1) && (nrun > 0) && (nrun <= NRUN);
  tot_smp = 0;
  for (r = 0; ok && r < nrun; r++) begin
    n  = $fscanf(fd, "%d %d %d %d", va, vb, vc, vd);
    ok = (n == 4) && (va >= 0) && (va < 2**AAW) && (vd > 0) && (vd <= NSMP);
    if (ok) begin
      len[r]  = va;
      cnt[r]  = vb;
      lvl[r]  = vc;
      nsmp[r] = vd;
      tot_smp += vd;
    end
    for (i = 0; ok && i < nsmp[r]; i++) begin
      n        = $fscanf(fd, "%d %d", va, vb);
      ok       = n == 2;
      sa[r][i] = va;
      sb[r][i] = vb;
    end
    for (i = 0; ok && i <= len[r]; i++) begin
      n        = $fscanf(fd, "%d %d", va, vb);
      ok       = n == 2;
      ea[r][i] = va;
      eb[r][i] = vb;
    end
  end
  $fclose(fd);
endtask

////////////////////
// run steps
////////////////////

task automatic start_run(input int r);
  run_base = beat_tot;
  cfg_len <= adr_t'(len[r]);
  cfg_cnt <= cnt_t'(cnt[r]);
  cfg_lvl <= smp_t'(lvl[r]);
  ctl_run <= 1'b1;
  @(posedge clk);
  ctl_run <= 1'b0;
  check_flag($sformatf("run%0d sts_run at start", r), 1'b0, sts_run);
  @(posedge clk);
  check_flag($sformatf("run%0d sts_run one cycle later", r), 1'b1, sts_run);
endtask

// hold each pair until the stream takes it
task automatic send_samples(input int r);
  int i;
  for (i = 0; i < nsmp[r]; i++) begin
    sti_valid <= 1'b1;
    sti_a     <= smp_t'(sa[r][i]);
    sti_b     <= smp_t'(sb[r][i]);
    @(posedge clk);
    while (!sti_ready) @(posedge clk);
  end
  sti_valid <= 1'b0;
endtask

task automatic wait_run_end(input int r);
  while (sts_run) @(posedge clk);  // drops after the final accept
  check_cnt($sformatf("run%0d sts_cnt", r), '0, sts_cnt);  // wrapped
  while (beat_tot - run_base < len[r] + 1) @(posedge clk);
  repeat (8) @(posedge clk);  // room for stray beats
endtask

task automatic check_outputs(input int r);
  int i;
  int n;
  n = beat_tot - run_base;
  if (n != len[r] + 1) begin
    err_oth++;
    $display("run%0d gave %0d output beats instead of %0d", r, n, len[r] + 1);
  end
  for (i = 0; i < n && i <= len[r] && run_base + i < NBEAT; i++) begin
    check_sum($sformatf("run%0d sto_a[%0d]", r, i), sum_t'(ea[r][i]), got_a[run_base + i]);
    check_sum($sformatf("run%0d sto_b[%0d]", r, i), sum_t'(eb[r][i]), got_b[run_base + i]);
    check_flag($sformatf("run%0d sto_last[%0d]", r, i), i == len[r], got_l[run_base + i]);
  end
endtask

// one read at a time, data one cycle after the request
task automatic read_memories(input int r);
  int ch;
  int a;
  for (ch = 0; ch < 2; ch++) begin
    for (a = 0; a <= len[r]; a++) begin
      bus_ren <= 1'b1;
      bus_ch  <= ch[0];
      bus_adr <= adr_t'(a);
      @(posedge clk);
      bus_ren <= 1'b0;
      check_flag($sformatf("run%0d bus_vld early ch%0d[%0d]", r, ch, a), 1'b0, bus_vld);
      @(posedge clk);
      check_flag($sformatf("run%0d bus_vld ch%0d[%0d]", r, ch, a), 1'b1, bus_vld);
      check_sum($sformatf("run%0d bus_rdt ch%0d[%0d]", r, ch, a),
                sum_t'(ch == 0 ? ea[r][a] : eb[r][a]), bus_rdt);
    end
  end
endtask

// start and read requests land in the clear cycle and must be overridden
task automatic clear_dut();
  clr     <= 1'b1;
  ctl_run <= 1'b1;
  bus_ren <= 1'b1;
  @(posedge clk);
  clr     <= 1'b0;
  ctl_run <= 1'b0;
  bus_ren <= 1'b0;
  @(posedge clk);
  check_flag("sts_run after clr", 1'b0, sts_run);
  check_flag("bus_vld after clr", 1'b0, bus_vld);
endtask

////////////////////
// main sequence
////////////////////

initial begin
  load_data(load_ok);
  if (!load_ok) begin
    $display("the test data file is missing or malformed");
    $display("SIMULATION FAILED");
    $finish;
  end else begin
    limit = tot_smp * 4 + 500;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    for (int r = 0; r < nrun; r++) begin
      start_run(r);
      send_samples(r);
      wait_run_end(r);
      check_outputs(r);
      read_memories(r);
      clear_dut();  // next run must start clean
    end
    $display("error counts: %0d mismatches, %0d other", err_mis, err_oth);
    if (err_mis + err_oth == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end
end

endmodule

//--- dv/acum_testdata.txt
# line 3 run count; per run "cfg_len cfg_cnt cfg_lvl nsmp", then nsmp lines "smp_a smp_b"
# then cfg_len+1 lines "sum_a sum_b" of expected final sums by index, all signed decimal
2
3 2 100 19
150 7
20 -3
120 10
90 -20
-40 5
200 1000
50 9
60 9
99 4
100 -8
30 11
-100 -12
500 13
0 1
-5 2
101 30
150 -60
7 0
-8191 -8192
321 32
270 -69
-133 -7
-7491 -7179
5 1 -50 17
-10 4
-60 1
-51 2
-50 100
-300 -1
8191 8191
0 -50
12 6
-1 -1
-70 0
-80 0
40 -7
-40 2
8191 8191
25 50
-12 -6
-2 3
-10 93
-340 1
16382 16382
25 0
0 0
-3 2

//--- src.f
rtl/acum_pkg.sv
rtl/acum_trig.sv
rtl/acum_core.sv
rtl/acum_combine.sv
rtl/acum_top.sv
dv/acum_tb.sv

//--- run.sh
#!/bin/sh
# build the averager testbench with Verilator and run it
# status follows the pass message in the simulation output
verilator --binary --top-module acum_tb -f src.f -o acum_sim \
  && ./obj_dir/acum_sim | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
  && echo "averager run ok" \
  || { echo "averager run not ok"; exit 1; }
